// ==== list.f ====
+incdir+source
source/ddr3_lite_pkg.sv
source/ddr3_cfg.sv
source/ddr3_req_fifo.sv
source/ddr3_fsm.sv
source/ddr3_ddl.sv
source/ddr3_lite_top.sv
tests/dfi_mem_model.sv
tests/ddr3_lite_tb.sv

// ==== Bender.yml ====
package:
  name: ddr3_lite

sources:
  - include_dirs:
      - source
    files:
      - source/ddr3_lite_pkg.sv
      - source/ddr3_cfg.sv
      - source/ddr3_req_fifo.sv
      - source/ddr3_fsm.sv
      - source/ddr3_ddl.sv
      - source/ddr3_lite_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/dfi_mem_model.sv
      - tests/ddr3_lite_tb.sv

// ==== tests/ddr3_lite_tb.sv ====
`include "ddr3_lite_consts.svh"

module ddr3_lite_tb import ddr3_lite_pkg::*; ();
  localparam int N_REQ = 400;
  localparam int INIT_LEN = `DDR_RESET_CYCLES + `DDR_CKE_CYCLES + 4 * `DDR_TMRD + 32;
  localparam int TIMEOUT = 8 + INIT_LEN + N_REQ * 60;
  localparam int MRS_FIRST = `DDR_RESET_CYCLES + `DDR_CKE_CYCLES + 1;

  logic clock, reset_i, req_i;
  mem_req_t req_data_i, req;
  logic configured_o, ack_o, dfi_rst_n, dfi_cke;
  rd_ret_t rd_o, dfi_rd;
  dfi_cmd_t dfi_cmd;
  dfi_wdata_t dfi_wdata;
  int model_errors;
  int errors = 0;
  int cycles = 0;
  int since_rel = 0;
  int reads_acked = 0;
  int reads_back = 0;
  logic ack_seen = 1'b0;
  logic [31:0] lfsr;
  logic [31:0] sb [logic [25:0]];  // Scoreboard memory
  logic [31:0] exp_q[$];           // Expected read words in request order
  ddr_cmd_e exp_cmd;

  ddr3_lite_top ddr3_lite_top_i (
    .clock(clock), .reset_i(reset_i), .configured_o(configured_o),
    .req_i(req_i), .req_data_i(req_data_i), .ack_o(ack_o), .rd_o(rd_o),
    .dfi_rst_no(dfi_rst_n), .dfi_cke_o(dfi_cke), .dfi_cmd_o(dfi_cmd),
    .dfi_wdata_o(dfi_wdata), .dfi_rd_i(dfi_rd)
  );

  dfi_mem_model mem_model_i (
    .clock(clock), .reset_i(reset_i), .active_i(configured_o), .dfi_cmd_i(dfi_cmd),
    .dfi_wdata_i(dfi_wdata), .dfi_rd_o(dfi_rd), .errors_o(model_errors)
  );

  always #20 clock = ~clock;

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // Fibonacci LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [25:0] a);
    return {a, 6'h2b} ^ (32'(a) * 32'h9e37_79b1);
  endfunction

  function automatic logic [31:0] apply_mask(input logic [31:0] old, input logic [31:0] d,
                                             input logic [3:0] m);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (!m[i]) r[8*i +: 8] = d[8*i +: 8];
    end
    return r;
  endfunction

  // Two banks and three rows so hits, misses and conflicts mix
  function automatic mem_req_t random_req();
    mem_req_t r;
    r = '0;
    r.write = 1'(rand_bits(1));
    r.bank = 3'(rand_bits(1));
    r.row = 13'(rand_bits(2) % 3);
    r.col = 10'(rand_bits(3));
    r.data = rand_bits(32);
    r.mask = 4'(rand_bits(4));
    return r;
  endfunction

  task automatic record(input mem_req_t r);
    logic [25:0] a;
    logic [31:0] cur;
    a = {r.bank, r.row, r.col};
    cur = sb.exists(a) ? sb[a] : fill_word(a);
    if (r.write) begin
      sb[a] = apply_mask(cur, r.data, r.mask);
    end else begin
      exp_q.push_back(cur);
      reads_acked++;
    end
  endtask

  initial begin
    clock = 1'b0;
    reset_i = 1'b1;
    req_i = 1'b0;
    req_data_i = '0;
    lfsr = 32'd73660;
    repeat (8) @(posedge clock);
    reset_i <= 1'b0;
    // First request is held through init and waits for configured_o
    for (int k = 0; k < N_REQ; k++) begin
      req = random_req();
      req_i <= 1'b1;  // Next request follows each ack back-to-back
      req_data_i <= req;
      do @(posedge clock); while (!ack_o);
      record(req);
    end
    req_i <= 1'b0;
    while (reads_back < reads_acked) @(posedge clock);
    repeat (16) @(posedge clock);
    assert (reads_back == reads_acked) else
      report_error($sformatf("%0d reads returned, %0d acknowledged", reads_back, reads_acked));
    $display("summary: %0d testbench errors, %0d model errors, %0d reads checked",
             errors, model_errors, reads_back);
    if (errors + model_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Run stopped, did not finish within %0d cycles", TIMEOUT);
      $display("Regression failed");
      $finish;
    end
  end

  // Init sequence counted in edges after reset release
  always @(posedge clock) begin
    since_rel <= reset_i ? 0 : since_rel + 1;
    if (!reset_i && since_rel <= INIT_LEN + 1) begin
      exp_cmd = CMD_NOP;
      for (int i = 0; i < 4; i++)
        if (!reset_i && since_rel == MRS_FIRST + i * `DDR_TMRD) exp_cmd = CMD_MRS;
      if (!reset_i && since_rel == MRS_FIRST + 4 * `DDR_TMRD) exp_cmd = CMD_ZQCL;
      assert (dfi_cmd.cmd == exp_cmd) else
        report_error($sformatf("init command %s, expected %s", dfi_cmd.cmd.name(),
                               exp_cmd.name()));
      assert (dfi_rst_n == (!reset_i && since_rel >= `DDR_RESET_CYCLES)) else
        report_error("dfi_rst_no out of sequence");
      assert (dfi_cke == (!reset_i && since_rel >= `DDR_RESET_CYCLES + `DDR_CKE_CYCLES)) else
        report_error("CKE out of sequence");
      assert (configured_o == (!reset_i && since_rel > INIT_LEN)) else
        report_error("configured_o not at its fixed cycle");
      assert (!rd_o.valid && !dfi_wdata.en) else report_error("data activity during init");
    end
  end

  // Handshake and read return
  always @(posedge clock) begin
    if (ack_o) begin
      assert (configured_o) else report_error("ack_o before configured_o");
      assert (req_i) else report_error("ack_o without a request");
      assert (!ack_seen) else report_error("second ack_o for one request");
    end
    ack_seen <= ack_o;
    if (rd_o.valid) begin
      reads_back++;
      if (exp_q.size() == 0) begin
        report_error("read data returned with no read pending");
      end else begin
        assert (rd_o.data == exp_q[0]) else
          report_error($sformatf("read data %h, expected %h", rd_o.data, exp_q[0]));
        void'(exp_q.pop_front());
      end
    end
  end

endmodule

// ==== tests/dfi_mem_model.sv ====
`include "ddr3_lite_consts.svh"

module dfi_mem_model import ddr3_lite_pkg::*; (
  input  logic       clock,
  input  logic       reset_i,
  input  logic       active_i,     // Controller configured
  input  dfi_cmd_t   dfi_cmd_i,
  input  dfi_wdata_t dfi_wdata_i,
  output rd_ret_t    dfi_rd_o,
  output int         errors_o
);
  localparam int NBANKS = 1 << `DDR_BANK_BITS;
  localparam int REF_LIMIT = `DDR_REFRESH_INTERVAL + 60;  // Interval plus service bound
  localparam int AW = `DDR_BANK_BITS + `DDR_ROW_BITS + `DDR_COL_BITS;

  logic [`DDR_DATA_BITS-1:0] mem [logic [AW-1:0]];
  logic [NBANKS-1:0] open_bank;
  logic [`DDR_ROW_BITS-1:0] open_row [NBANKS];
  int act_at [NBANKS];
  int pre_at [NBANKS];
  int ref_at, cyc, since_ref;
  int errors = 0;
  int wr_due[$];
  int rd_due[$];
  logic [AW-1:0] wr_addr[$];
  logic [AW-1:0] rd_addr[$];

  assign errors_o = errors;

  task automatic flag(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // Unwritten words read back as a pattern of the full address
  function automatic logic [31:0] initial_word(input logic [AW-1:0] a);
    return {a, 6'h2b} ^ (32'(a) * 32'h9e37_79b1);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] m);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (!m[i]) r[8*i +: 8] = d[8*i +: 8];  // Set mask bit keeps the byte
    end
    return r;
  endfunction

  always @(posedge clock) begin
    logic [AW-1:0] a;
    int b;
    if (reset_i) begin
      open_bank = '0;
      cyc = 0;
      since_ref = 0;
      ref_at = -1000;
      for (int i = 0; i < NBANKS; i++) begin
        act_at[i] = -1000;
        pre_at[i] = -1000;
      end
      wr_due.delete();
      rd_due.delete();
      wr_addr.delete();
      rd_addr.delete();
      dfi_rd_o <= '0;
    end else begin
      cyc++;
      dfi_rd_o <= '0;
      b = dfi_cmd_i.bank;
      if (dfi_cmd_i.cmd != CMD_NOP)
        assert (cyc - ref_at >= `DDR_TRFC) else flag("command inside tRFC after REF");
      case (dfi_cmd_i.cmd)
        CMD_ACT: begin
          assert (!open_bank[b]) else flag($sformatf("ACT to open bank %0d", b));
          assert (cyc - pre_at[b] >= `DDR_TRP) else flag("ACT inside tRP after PRE");
          open_bank[b] = 1'b1;
          open_row[b] = dfi_cmd_i.addr;
          act_at[b] = cyc;
        end
        CMD_PRE: begin
          for (int i = 0; i < NBANKS; i++) begin
            if (dfi_cmd_i.addr[10] || i == b) begin
              open_bank[i] = 1'b0;
              pre_at[i] = cyc;
            end
          end
        end
        CMD_RD, CMD_WR: begin
          assert (open_bank[b]) else flag($sformatf("access to closed bank %0d", b));
          assert (cyc - act_at[b] >= `DDR_TRCD) else flag("access inside tRCD after ACT");
          a = {3'(b), open_row[b], dfi_cmd_i.addr[`DDR_COL_BITS-1:0]};
          if (dfi_cmd_i.cmd == CMD_WR) begin
            wr_due.push_back(cyc + `DDR_CWL);
            wr_addr.push_back(a);
          end else begin
            rd_due.push_back(cyc + `DDR_CL);
            rd_addr.push_back(a);
          end
        end
        CMD_REF: begin
          assert (open_bank == '0) else flag("REF with a bank open");
          for (int i = 0; i < NBANKS; i++)
            assert (cyc - pre_at[i] >= `DDR_TRP) else flag("REF inside tRP after PRE");
          ref_at = cyc;
          since_ref = 0;
        end
        default: ;
      endcase
      // Write data lands exactly CWL after its WR
      if (wr_due.size() > 0 && wr_due[0] == cyc) begin
        assert (dfi_wdata_i.en) else flag("write enable missing CWL after WR");
        a = wr_addr.pop_front();
        void'(wr_due.pop_front());
        mem[a] = merge_bytes(mem.exists(a) ? mem[a] : initial_word(a),
                             dfi_wdata_i.data, dfi_wdata_i.mask);
      end else begin
        assert (!dfi_wdata_i.en) else flag("write enable without a WR CWL before");
      end
      if (rd_due.size() > 0 && rd_due[0] == cyc) begin
        a = rd_addr.pop_front();
        void'(rd_due.pop_front());
        dfi_rd_o <= '{1'b1, mem.exists(a) ? mem[a] : initial_word(a)};
      end
      if (active_i) begin
        since_ref++;
        assert (since_ref != REF_LIMIT) else flag("no REF within the refresh bound");
      end
    end
  end

endmodule

// ==== source/ddr3_lite_top.sv ====
module ddr3_lite_top import ddr3_lite_pkg::*; (
  input  logic       clock,
  input  logic       reset_i,
  output logic       configured_o,
  input  logic       req_i,
  input  mem_req_t   req_data_i,
  output logic       ack_o,
  output rd_ret_t    rd_o,
  output logic       dfi_rst_no,
  output logic       dfi_cke_o,
  output dfi_cmd_t   dfi_cmd_o,
  output dfi_wdata_t dfi_wdata_o,
  input  rd_ret_t    dfi_rd_i
);
  dfi_cmd_t cfg_cmd, fsm_cmd, sel_cmd;
  dfi_wdata_t wr_word;
  mem_req_t head;
  logic cfg_run, ref_req, ref_ack;
  logic head_valid, pop;
  logic fsm_reset;

  // Init commands own the DFI until the sequencer hands over
  assign sel_cmd = cfg_run ? fsm_cmd : cfg_cmd;
  assign fsm_reset = reset_i || !cfg_run;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      configured_o <= 1'b0;
    end else begin
      configured_o <= cfg_run;
    end
  end

  ddr3_cfg ddr3_cfg_i (
    .clock     (clock),
    .reset_i   (reset_i),
    .dfi_rst_no(dfi_rst_no),
    .dfi_cke_o (dfi_cke_o),
    .cfg_cmd_o (cfg_cmd),
    .cfg_run_o (cfg_run),
    .ref_req_o (ref_req),
    .ref_ack_i (ref_ack)
  );

  ddr3_req_fifo ddr3_req_fifo_i (
    .clock       (clock),
    .reset_i     (reset_i),
    .enable_i    (configured_o),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .ack_o       (ack_o),
    .head_valid_o(head_valid),
    .head_o      (head),
    .pop_i       (pop)
  );

  ddr3_fsm ddr3_fsm_i (
    .clock       (clock),
    .reset_i     (fsm_reset),
    .head_valid_i(head_valid),
    .head_i      (head),
    .pop_o       (pop),
    .ref_req_i   (ref_req),
    .ref_ack_o   (ref_ack),
    .cmd_o       (fsm_cmd),
    .wr_word_o   (wr_word)
  );

  ddr3_ddl ddr3_ddl_i (
    .clock      (clock),
    .reset_i    (reset_i),
    .cmd_i      (sel_cmd),
    .wr_word_i  (wr_word),
    .dfi_cmd_o  (dfi_cmd_o),
    .dfi_wdata_o(dfi_wdata_o),
    .dfi_rd_i   (dfi_rd_i),
    .rd_o       (rd_o)
  );

endmodule

// ==== source/ddr3_ddl.sv ====
`include "ddr3_lite_consts.svh"

module ddr3_ddl import ddr3_lite_pkg::*; (
  input  logic       clock,
  input  logic       reset_i,
  input  dfi_cmd_t   cmd_i,
  input  dfi_wdata_t wr_word_i,
  output dfi_cmd_t   dfi_cmd_o,
  output dfi_wdata_t dfi_wdata_o,
  input  rd_ret_t    dfi_rd_i,
  output rd_ret_t    rd_o
);
  dfi_wdata_t wr_line [`DDR_CWL];  // Writes in flight
  dfi_wdata_t wr_in;

  // Only a WR slot may launch write data
  always_comb begin
    wr_in = wr_word_i;
    wr_in.en = wr_word_i.en && (cmd_i.cmd == CMD_WR);
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      dfi_cmd_o <= '{CMD_NOP, '0, '0};
    end else begin
      dfi_cmd_o <= cmd_i;
    end
  end

  // Stage 0 lines up with WR on dfi_cmd_o, output lands CWL cycles later
  always_ff @(posedge clock) begin
    if (reset_i) begin
      for (int i = 0; i < `DDR_CWL; i++) begin
        wr_line[i] <= '0;
      end
      dfi_wdata_o <= '0;
    end else begin
      wr_line[0] <= wr_in;
      for (int i = 1; i < `DDR_CWL; i++) begin
        wr_line[i] <= wr_line[i-1];
      end
      dfi_wdata_o <= wr_line[`DDR_CWL-1];
    end
  end

  // Read return, in issue order
  always_ff @(posedge clock) begin
    if (reset_i) begin
      rd_o <= '0;
    end else begin
      rd_o <= dfi_rd_i;
    end
  end

endmodule

// ==== source/ddr3_fsm.sv ====
`include "ddr3_lite_consts.svh"

module ddr3_fsm import ddr3_lite_pkg::*; (
  input  logic       clock,
  input  logic       reset_i,
  input  logic       head_valid_i,
  input  mem_req_t   head_i,
  output logic       pop_o,
  input  logic       ref_req_i,
  output logic       ref_ack_o,
  output dfi_cmd_t   cmd_o,
  output dfi_wdata_t wr_word_o
);
  localparam int WAIT_W = $clog2(`DDR_TRFC);
  localparam int NBANKS = 1 << `DDR_BANK_BITS;
  localparam logic [`DDR_ROW_BITS-1:0] ADDR_A10 = 1 << 10;

  fsm_state_e state, ret_state;
  logic [WAIT_W-1:0] wait_cnt;
  logic [NBANKS-1:0] row_valid;  // Bank has an open row
  logic [`DDR_ROW_BITS-1:0] open_row [NBANKS];
  logic bank_open, row_hit;

  assign bank_open = row_valid[head_i.bank];
  assign row_hit = bank_open && (open_row[head_i.bank] == head_i.row);

  // Both take effect on the edge that registers the command
  assign pop_o = (state == FSM_ACCESS);
  assign ref_ack_o = (state == FSM_REF);

  // Wait loads are T-2: one cycle in WAIT exit, one in the issuing state
  always_ff @(posedge clock) begin
    if (reset_i) begin
      state <= FSM_IDLE;
      ret_state <= FSM_IDLE;
      wait_cnt <= '0;
      row_valid <= '0;
      cmd_o <= '{CMD_NOP, '0, '0};
      wr_word_o <= '0;
    end else begin
      cmd_o <= '{CMD_NOP, '0, '0};
      wr_word_o.en <= 1'b0;
      case (state)
        FSM_IDLE: begin
          if (ref_req_i) begin
            state <= FSM_PREA;  // Refresh wins over a queued request
          end else if (head_valid_i) begin
            if (row_hit) begin
              state <= FSM_ACCESS;
            end else if (bank_open) begin
              state <= FSM_PRE;
            end else begin
              state <= FSM_ACT;
            end
          end
        end
        FSM_PRE: begin
          cmd_o <= '{CMD_PRE, head_i.bank, '0};
          row_valid[head_i.bank] <= 1'b0;
          wait_cnt <= WAIT_W'(`DDR_TRP - 2);
          ret_state <= FSM_ACT;
          state <= FSM_WAIT;
        end
        FSM_ACT: begin
          cmd_o <= '{CMD_ACT, head_i.bank, head_i.row};
          row_valid[head_i.bank] <= 1'b1;
          wait_cnt <= WAIT_W'(`DDR_TRCD - 2);
          ret_state <= FSM_ACCESS;
          state <= FSM_WAIT;
        end
        FSM_ACCESS: begin
          cmd_o.bank <= head_i.bank;
          cmd_o.addr <= `DDR_ROW_BITS'(head_i.col);  // A10 low, no auto-precharge
          if (head_i.write) begin
            cmd_o.cmd <= CMD_WR;
            wr_word_o <= '{1'b1, head_i.mask, head_i.data};
          end else begin
            cmd_o.cmd <= CMD_RD;
          end
          state <= FSM_IDLE;
        end
        FSM_PREA: begin
          if (|row_valid) begin
            cmd_o <= '{CMD_PRE, '0, ADDR_A10};  // Precharge all
            row_valid <= '0;
            wait_cnt <= WAIT_W'(`DDR_TRP - 2);
            ret_state <= FSM_REF;
            state <= FSM_WAIT;
          end else begin
            state <= FSM_REF;
          end
        end
        FSM_REF: begin
          cmd_o <= '{CMD_REF, '0, '0};
          wait_cnt <= WAIT_W'(`DDR_TRFC - 2);
          ret_state <= FSM_IDLE;
          state <= FSM_WAIT;
        end
        FSM_WAIT: begin
          if (wait_cnt == '0) begin
            state <= ret_state;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: state <= FSM_IDLE;
      endcase
    end
  end

  // Open-row table, rows only; validity lives in row_valid
  always_ff @(posedge clock) begin
    if (state == FSM_ACT) begin
      open_row[head_i.bank] <= head_i.row;
    end
  end

endmodule

// ==== source/ddr3_req_fifo.sv ====
`include "ddr3_lite_consts.svh"

module ddr3_req_fifo import ddr3_lite_pkg::*; (
  input  logic     clock,
  input  logic     reset_i,
  input  logic     enable_i,
  input  logic     req_i,
  input  mem_req_t req_data_i,
  output logic     ack_o,
  output logic     head_valid_o,
  output mem_req_t head_o,
  input  logic     pop_i
);
  localparam int PTR_W = $clog2(`REQ_DEPTH);
  localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

  mem_req_t queue [`REQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic full, push, pop;

  assign full = (count == CNT_W'(`REQ_DEPTH));
  // Request still high in the ack cycle is the one just taken
  assign push = enable_i && req_i && !ack_o && !full;
  assign pop = pop_i && head_valid_o;
  assign head_valid_o = (count != '0);
  assign head_o = queue[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= push;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      queue[wr_ptr] <= req_data_i;
    end
  end

endmodule

// ==== source/ddr3_cfg.sv ====
`include "ddr3_lite_consts.svh"

module ddr3_cfg import ddr3_lite_pkg::*; (
  input  logic     clock,
  input  logic     reset_i,
  output logic     dfi_rst_no,
  output logic     dfi_cke_o,
  output dfi_cmd_t cfg_cmd_o,
  output logic     cfg_run_o,
  output logic     ref_req_o,
  input  logic     ref_ack_i
);
  localparam int CNT_W = $clog2(`DDR_REFRESH_INTERVAL);
  localparam int ZQ_CYCLES = 32;  // ZQCL to first controller command

  cfg_state_e state;
  logic [CNT_W-1:0] count;
  logic [1:0] mr_idx;  // 0..3 walks MR2, MR3, MR1, MR0

  assign dfi_rst_no = (state != CFG_RESET);
  assign dfi_cke_o = (state != CFG_RESET) && (state != CFG_CKE);
  assign cfg_run_o = (state == CFG_RUN);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state <= CFG_RESET;
      count <= CNT_W'(`DDR_RESET_CYCLES - 1);
      mr_idx <= '0;
      ref_req_o <= 1'b0;
    end else begin
      count <= count - 1'b1;
      case (state)
        CFG_RESET: if (count == '0) begin
          state <= CFG_CKE;
          count <= CNT_W'(`DDR_CKE_CYCLES - 1);
        end
        CFG_CKE: if (count == '0) begin
          state <= CFG_MRS;
          count <= CNT_W'(`DDR_TMRD - 1);
        end
        CFG_MRS: if (count == '0) begin
          count <= CNT_W'(`DDR_TMRD - 1);
          mr_idx <= mr_idx + 1'b1;
          if (mr_idx == 2'd3) begin
            state <= CFG_ZQ;
            count <= CNT_W'(ZQ_CYCLES - 1);
          end
        end
        CFG_ZQ: if (count == '0) begin
          state <= CFG_RUN;
          count <= CNT_W'(`DDR_REFRESH_INTERVAL - 1);
        end
        default: begin
          // Refresh interval timer, request held until serviced
          if (ref_ack_i) begin
            ref_req_o <= 1'b0;
          end
          if (count == '0) begin
            ref_req_o <= 1'b1;
            count <= CNT_W'(`DDR_REFRESH_INTERVAL - 1);
          end
        end
      endcase
    end
  end

  // One command in the first cycle of each MRS slot and of the ZQ wait
  always_comb begin
    cfg_cmd_o = '{CMD_NOP, '0, '0};
    if (state == CFG_MRS && count == CNT_W'(`DDR_TMRD - 1)) begin
      cfg_cmd_o.cmd = CMD_MRS;
      case (mr_idx)
        2'd0: begin
          cfg_cmd_o.bank = 3'd2;
          cfg_cmd_o.addr[5:3] = 3'(`DDR_CWL - 5);  // CWL field
        end
        2'd1: cfg_cmd_o.bank = 3'd3;
        2'd2: begin
          cfg_cmd_o.bank = 3'd1;
          cfg_cmd_o.addr[0] = 1'b1;  // DLL disabled
        end
        default: begin
          cfg_cmd_o.bank = 3'd0;
          cfg_cmd_o.addr[6:4] = 3'(`DDR_CL - 4);  // CAS latency, BL8
        end
      endcase
    end else if (state == CFG_ZQ && count == CNT_W'(ZQ_CYCLES - 1)) begin
      cfg_cmd_o.cmd = CMD_ZQCL;
      cfg_cmd_o.addr[10] = 1'b1;  // Long calibration
    end
  end

endmodule

// ==== source/ddr3_lite_pkg.sv ====
`include "ddr3_lite_consts.svh"

package ddr3_lite_pkg;

  typedef struct packed {
    logic                      write;
    logic [`DDR_BANK_BITS-1:0] bank;
    logic [`DDR_ROW_BITS-1:0]  row;
    logic [`DDR_COL_BITS-1:0]  col;
    logic [`DDR_DATA_BITS-1:0] data;
    logic [`DDR_MASK_BITS-1:0] mask;  // High bit masks a byte
  } mem_req_t;

  // {RAS#, CAS#, WE#} as seen on the DFI
  typedef enum logic [2:0] {
    CMD_MRS  = 3'b000,
    CMD_REF  = 3'b001,
    CMD_PRE  = 3'b010,
    CMD_ACT  = 3'b011,
    CMD_WR   = 3'b100,
    CMD_RD   = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOP  = 3'b111
  } ddr_cmd_e;

  typedef struct packed {
    ddr_cmd_e                  cmd;
    logic [`DDR_BANK_BITS-1:0] bank;
    logic [`DDR_ROW_BITS-1:0]  addr;
  } dfi_cmd_t;

  typedef struct packed {
    logic                      en;
    logic [`DDR_MASK_BITS-1:0] mask;
    logic [`DDR_DATA_BITS-1:0] data;
  } dfi_wdata_t;

  typedef struct packed {
    logic                      valid;
    logic [`DDR_DATA_BITS-1:0] data;
  } rd_ret_t;

  typedef enum logic [2:0] {CFG_RESET, CFG_CKE, CFG_MRS, CFG_ZQ, CFG_RUN} cfg_state_e;

  typedef enum logic [2:0] {
    FSM_IDLE,
    FSM_PRE,
    FSM_ACT,
    FSM_ACCESS,
    FSM_PREA,
    FSM_REF,
    FSM_WAIT
  } fsm_state_e;

endpackage

// ==== source/ddr3_lite_consts.svh ====
`ifndef DDR3_LITE_CONSTS_SVH
`define DDR3_LITE_CONSTS_SVH

// Address and data widths
`define DDR_BANK_BITS 3
`define DDR_ROW_BITS 13
`define DDR_COL_BITS 10
`define DDR_DATA_BITS 32
`define DDR_MASK_BITS 4

// Timing in controller clocks
`define DDR_CL 6
`define DDR_CWL 5
`define DDR_TRCD 4
`define DDR_TRP 4
`define DDR_TRFC 20
`define DDR_TMRD 4

`define DDR_REFRESH_INTERVAL 300
`define DDR_RESET_CYCLES 16  // dfi_rst_no held low
`define DDR_CKE_CYCLES 8     // Reset release to CKE
`define REQ_DEPTH 4

`endif
